/* logic/fighter_pkg.sv */
package fighter_pkg;

    // one action per frame, decoded from the pad
    typedef enum logic [2:0] {
        ACT_IDLE,
        ACT_LEFT,
        ACT_RIGHT,
        ACT_SQUAT,
        ACT_DEFEND,
        ACT_JUMP
    } action_t;

    typedef enum logic {
        JS_GROUND,
        JS_AIR
    } jump_state_t;

    // coordinate widths
    localparam int X_W = 11;
    localparam int Y_W = 10;

    // horizontal limits and step
    localparam int MAX_X  = 1279;
    localparam int STEP_X = 4;

    // jump arc, y = y0 + VEL*k - GRAV*k*k/2
    localparam int MAX_Y = 719;
    localparam int MAX_J = 10;
    localparam int GRAV  = 4;
    localparam int VEL   = 20;

    // step counter width, covers 0 to MAX_J
    localparam int J_W = $clog2(MAX_J + 1);

    // action queue
    localparam int Q_DEPTH = 4;
    localparam int Q_AW    = $clog2(Q_DEPTH);

endpackage

/* logic/action_if.sv */
`timescale 1ns/100ps

interface action_if;

    logic                 avail;
    fighter_pkg::action_t act;
    logic                 pop;
    logic                 overflow;

    modport queue (
        output avail,
        output act,
        output overflow,
        input  pop
    );

    modport motion (
        input  avail,
        input  act,
        input  overflow,
        output pop
    );

endinterface

/* logic/pad_decoder.sv */
`timescale 1ns/100ps

module pad_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 frame_tick,
    input  logic                 right,
    input  logic                 left,
    input  logic                 jump,
    input  logic                 squat,
    input  logic                 defend,
    output logic                 push,
    output fighter_pkg::action_t push_act
);

    fighter_pkg::action_t next_act;

    // fixed priority: jump, defend, squat, right, left
    always_comb begin
        if (jump) begin
            next_act = fighter_pkg::ACT_JUMP;
        end else if (defend) begin
            next_act = fighter_pkg::ACT_DEFEND;
        end else if (squat) begin
            next_act = fighter_pkg::ACT_SQUAT;
        end else if (right) begin
            next_act = fighter_pkg::ACT_RIGHT;
        end else if (left) begin
            next_act = fighter_pkg::ACT_LEFT;
        end else begin
            next_act = fighter_pkg::ACT_IDLE;
        end
    end

    // one push per tick, one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= frame_tick;
        end
    end

    // buttons are sampled at the tick edge
    always_ff @(posedge clk) begin
        if (frame_tick) begin
            push_act <= next_act;
        end
    end

endmodule

/* logic/action_queue.sv */
`timescale 1ns/100ps

module action_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  fighter_pkg::action_t push_act,
    action_if.queue              q,
    output logic                 queue_empty
);

    fighter_pkg::action_t mem [fighter_pkg::Q_DEPTH];

    logic [fighter_pkg::Q_AW-1:0] wr_ptr;
    logic [fighter_pkg::Q_AW-1:0] rd_ptr;
    logic [fighter_pkg::Q_AW:0]   count;
    logic                         full;
    logic                         do_push;
    logic                         do_pop;
    logic                         overflow_q;

    assign full    = (count == fighter_pkg::Q_DEPTH);
    assign do_push = push && !full;
    assign do_pop  = q.pop && (count != '0);

    assign q.avail     = (count != '0);
    assign q.act       = mem[rd_ptr];
    assign q.overflow  = overflow_q;
    assign queue_empty = (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // a push into a full queue is lost, remember it
            if (push && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_act;
        end
    end

endmodule

/* logic/player_motion.sv */
`timescale 1ns/100ps

module player_motion (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pause,
    action_if.motion                    a,
    output logic [fighter_pkg::X_W-1:0] pos_x,
    output logic [fighter_pkg::Y_W-1:0] pos_y,
    output logic                        jumping,
    output logic                        face,
    output logic                        squat_pose,
    output logic                        defend_pose
);

    logic [fighter_pkg::X_W-1:0] x_q, x_d;
    logic [fighter_pkg::Y_W-1:0] y_q, y_d;
    logic [fighter_pkg::Y_W-1:0] y0_q, y0_d;
    logic [fighter_pkg::J_W-1:0] k_q, k_d;
    fighter_pkg::jump_state_t    js_q, js_d;
    logic                        face_q, face_d;
    logic                        squat_q, squat_d;
    logic                        defend_q, defend_d;

    // wide signed scratch values for the saturating arithmetic
    int x_calc;
    int y_calc;

    // one action per cycle unless held off
    assign a.pop = a.avail && !pause;

    always_comb begin
        x_calc   = int'(x_q);
        y_calc   = int'(y_q);
        x_d      = x_q;
        y_d      = y_q;
        y0_d     = y0_q;
        k_d      = k_q;
        js_d     = js_q;
        face_d   = face_q;
        squat_d  = squat_q;
        defend_d = defend_q;

        if (a.pop) begin
            // poses last for one step, no squatting in the air
            squat_d  = (a.act == fighter_pkg::ACT_SQUAT) && (js_q == fighter_pkg::JS_GROUND);
            defend_d = (a.act == fighter_pkg::ACT_DEFEND);

            case (a.act)
                fighter_pkg::ACT_LEFT: begin
                    x_calc = int'(x_q) - fighter_pkg::STEP_X;
                    face_d = 1'b0;
                end
                fighter_pkg::ACT_RIGHT: begin
                    x_calc = int'(x_q) + fighter_pkg::STEP_X;
                    face_d = 1'b1;
                end
                default: begin
                    x_calc = int'(x_q);
                end
            endcase
            if (x_calc < 0) begin
                x_calc = 0;
            end else if (x_calc > fighter_pkg::MAX_X) begin
                x_calc = fighter_pkg::MAX_X;
            end
            x_d = x_calc[fighter_pkg::X_W-1:0];

            if (js_q == fighter_pkg::JS_AIR) begin
                y_calc = int'(y0_q) + fighter_pkg::VEL * int'(k_q)
                       - (fighter_pkg::GRAV * int'(k_q) * int'(k_q)) / 2;
                if (y_calc < 0) begin
                    y_calc = 0;
                end else if (y_calc > fighter_pkg::MAX_Y) begin
                    y_calc = fighter_pkg::MAX_Y;
                end
                y_d = y_calc[fighter_pkg::Y_W-1:0];
                // last arc step lands back on the ground
                if (k_q == fighter_pkg::MAX_J) begin
                    js_d = fighter_pkg::JS_GROUND;
                end else begin
                    k_d = k_q + 1'b1;
                end
            end else if (a.act == fighter_pkg::ACT_JUMP) begin
                y0_d = y_q;
                k_d  = '0;
                js_d = fighter_pkg::JS_AIR;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_q      <= '0;
            y_q      <= '0;
            y0_q     <= '0;
            k_q      <= '0;
            js_q     <= fighter_pkg::JS_GROUND;
            face_q   <= 1'b0;
            squat_q  <= 1'b0;
            defend_q <= 1'b0;
        end else begin
            x_q      <= x_d;
            y_q      <= y_d;
            y0_q     <= y0_d;
            k_q      <= k_d;
            js_q     <= js_d;
            face_q   <= face_d;
            squat_q  <= squat_d;
            defend_q <= defend_d;
        end
    end

    assign pos_x       = x_q;
    assign pos_y       = y_q;
    assign jumping     = (js_q == fighter_pkg::JS_AIR);
    assign face        = face_q;
    assign squat_pose  = squat_q;
    assign defend_pose = defend_q;

endmodule

/* logic/fighter_top.sv */
`timescale 1ns/100ps

module fighter_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        frame_tick,
    input  logic                        right,
    input  logic                        left,
    input  logic                        jump,
    input  logic                        squat,
    input  logic                        defend,
    input  logic                        pause,
    output logic [fighter_pkg::X_W-1:0] pos_x,
    output logic [fighter_pkg::Y_W-1:0] pos_y,
    output logic                        jumping,
    output logic                        face,
    output logic                        squat_pose,
    output logic                        defend_pose,
    output logic                        overflow,
    output logic                        queue_empty
);

    logic                 push;
    fighter_pkg::action_t push_act;

    action_if act_bus ();

    pad_decoder i_pad_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .right      (right),
        .left       (left),
        .jump       (jump),
        .squat      (squat),
        .defend     (defend),
        .push       (push),
        .push_act   (push_act)
    );

    action_queue i_action_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_act    (push_act),
        .q           (act_bus.queue),
        .queue_empty (queue_empty)
    );

    player_motion i_player_motion (
        .clk         (clk),
        .rst_n       (rst_n),
        .pause       (pause),
        .a           (act_bus.motion),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .jumping     (jumping),
        .face        (face),
        .squat_pose  (squat_pose),
        .defend_pose (defend_pose)
    );

    // sticky drop flag, read off the shared bus
    assign overflow = act_bus.overflow;

endmodule

/* dv/fighter_assert.sv */
`timescale 1ns/100ps

module fighter_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     avail,
    input logic                     pop,
    input logic                     overflow,
    input logic                     squat_pose,
    input fighter_pkg::jump_state_t js
);

    // the motion engine only takes a stored action
    pop_needs_avail: assert property (@(posedge clk) disable iff (!rst_n) pop |-> avail)
        else $error("pop while the queue holds nothing");

    overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n) overflow |=> overflow)
        else $error("overflow fell without a reset");

    no_squat_in_air: assert property (@(posedge clk) disable iff (!rst_n)
        !(squat_pose && js == fighter_pkg::JS_AIR))
        else $error("squat pose shown during a jump");

endmodule

// watches the bus between the queue and the motion engine and the motion outputs
bind fighter_top fighter_assert i_top_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .avail      (act_bus.avail),
    .pop        (act_bus.pop),
    .overflow   (act_bus.overflow),
    .squat_pose (squat_pose),
    .js         (i_player_motion.js_q)
);

/* dv/fighter_tb.sv */
`timescale 1ns/100ps

module fighter_tb;

    typedef logic [fighter_pkg::X_W-1:0] coord_t;

    // btn is {right, left, jump, squat, defend}
    typedef struct {
        logic [4:0]           btn;
        logic                 pause;
        fighter_pkg::action_t act;
    } frame_row_t;

    logic clk, rst_n, frame_tick, pause;
    logic right, left, jump, squat, defend;
    coord_t pos_x;
    logic [fighter_pkg::Y_W-1:0] pos_y;
    logic jumping, face, squat_pose, defend_pose, overflow, queue_empty;

    frame_row_t           rows[$];
    fighter_pkg::action_t held[$];
    int   errors = 0, checks = 0;
    int   m_x = 0, m_y = 0, m_y0 = 0, m_k = 0;
    logic m_air = 1'b0, m_face = 1'b0, m_squat = 1'b0, m_defend = 1'b0;
    logic m_ovf = 1'b0, timed_out = 1'b0;

    fighter_top i_dut (.*);

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_act(input string name, input fighter_pkg::action_t got,
                             input fighter_pkg::action_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %s, expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    // pad priority: jump, defend, squat, right, left
    function automatic fighter_pkg::action_t decode(input logic [4:0] b);
        if (b[2]) return fighter_pkg::ACT_JUMP;
        if (b[0]) return fighter_pkg::ACT_DEFEND;
        if (b[1]) return fighter_pkg::ACT_SQUAT;
        if (b[4]) return fighter_pkg::ACT_RIGHT;
        if (b[3]) return fighter_pkg::ACT_LEFT;
        return fighter_pkg::ACT_IDLE;
    endfunction

    // reference model, one call per popped action
    task automatic apply_model(input fighter_pkg::action_t act);
        m_squat  = (act == fighter_pkg::ACT_SQUAT) && !m_air;
        m_defend = (act == fighter_pkg::ACT_DEFEND);
        if (act == fighter_pkg::ACT_LEFT) begin
            m_x    = (m_x < fighter_pkg::STEP_X) ? 0 : m_x - fighter_pkg::STEP_X;
            m_face = 1'b0;
        end else if (act == fighter_pkg::ACT_RIGHT) begin
            m_x    = m_x + fighter_pkg::STEP_X;
            m_x    = (m_x > fighter_pkg::MAX_X) ? fighter_pkg::MAX_X : m_x;
            m_face = 1'b1;
        end
        if (m_air) begin
            m_y = m_y0 + fighter_pkg::VEL * m_k - (fighter_pkg::GRAV * m_k * m_k) / 2;
            m_y = (m_y < 0) ? 0 : ((m_y > fighter_pkg::MAX_Y) ? fighter_pkg::MAX_Y : m_y);
            if (m_k == fighter_pkg::MAX_J) begin
                m_air = 1'b0;
            end else begin
                m_k++;
            end
        end else if (act == fighter_pkg::ACT_JUMP) begin
            m_y0  = m_y;
            m_k   = 0;
            m_air = 1'b1;
        end
    endtask

    task automatic check_outputs();
        check_coord("pos_x", pos_x, coord_t'(m_x));
        check_coord("pos_y", coord_t'(pos_y), coord_t'(m_y));
        check_bit("jumping", jumping, m_air);
        check_bit("face", face, m_face);
        check_bit("squat_pose", squat_pose, m_squat);
        check_bit("defend_pose", defend_pose, m_defend);
        check_bit("overflow", overflow, m_ovf);
    endtask

    task automatic wait_empty(output int cycles);
        cycles = 0;
        while (!queue_empty && cycles < 50) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        if (!queue_empty) begin
            errors++;
            timed_out = 1'b1;
            $display("the action queue did not drain within 50 cycles");
        end
    endtask

    // stored actions leave one per cycle once pause drops
    task automatic release_pause();
        @(posedge clk);
        pause <= 1'b0;
        while (held.size() > 0) begin
            @(posedge clk);
            apply_model(held.pop_front());
            @(negedge clk);
            check_outputs();
        end
        check_bit("queue_empty", queue_empty, 1'b1);
    endtask

    task automatic run_frame(input frame_row_t r);
        int lat;
        @(posedge clk);
        frame_tick <= 1'b1;
        {right, left, jump, squat, defend} <= r.btn;
        pause <= r.pause;
        @(posedge clk);
        frame_tick <= 1'b0;
        @(negedge clk);
        check_bit("push", i_dut.push, 1'b1);
        check_act("push_act", i_dut.push_act, r.act);
        if (held.size() < fighter_pkg::Q_DEPTH)
            held.push_back(decode(r.btn));
        else
            m_ovf = 1'b1;
        @(posedge clk);
        @(negedge clk);
        // stored in the queue, not applied yet
        check_bit("queue_empty", queue_empty, 1'b0);
        check_outputs();
        if (!r.pause) begin
            wait_empty(lat);
            if (!timed_out) begin
                apply_model(held.pop_front());
                check_outputs();
                if (lat + 2 != 3) begin
                    errors++;
                    $display("outputs changed %0d cycles after frame_tick, not 3", lat + 2);
                end
            end
        end
    endtask

    task automatic add_row(input logic [4:0] btn, input logic hold,
                           input fighter_pkg::action_t act);
        frame_row_t r;
        r.btn   = btn;
        r.pause = hold;
        r.act   = act;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // into the right edge and back down to zero, idles keep the facing
        for (int i = 0; i < 325; i++)
            add_row(5'b10000, 1'b0, fighter_pkg::ACT_RIGHT);
        add_row(5'b00000, 1'b0, fighter_pkg::ACT_IDLE);
        add_row(5'b00000, 1'b0, fighter_pkg::ACT_IDLE);
        for (int i = 0; i < 325; i++)
            add_row(5'b01000, 1'b0, fighter_pkg::ACT_LEFT);
        add_row(5'b00000, 1'b0, fighter_pkg::ACT_IDLE);
        add_row(5'b10011, 1'b0, fighter_pkg::ACT_DEFEND);
        add_row(5'b11010, 1'b0, fighter_pkg::ACT_SQUAT);
        add_row(5'b11000, 1'b0, fighter_pkg::ACT_RIGHT);
        // take-off, then eleven arc steps with moves and a refused squat
        add_row(5'b00111, 1'b0, fighter_pkg::ACT_JUMP);
        add_row(5'b00000, 1'b0, fighter_pkg::ACT_IDLE);
        add_row(5'b10000, 1'b0, fighter_pkg::ACT_RIGHT);
        add_row(5'b10000, 1'b0, fighter_pkg::ACT_RIGHT);
        add_row(5'b00010, 1'b0, fighter_pkg::ACT_SQUAT);
        add_row(5'b10000, 1'b0, fighter_pkg::ACT_RIGHT);
        add_row(5'b01000, 1'b0, fighter_pkg::ACT_LEFT);
        add_row(5'b00000, 1'b0, fighter_pkg::ACT_IDLE);
        add_row(5'b00001, 1'b0, fighter_pkg::ACT_DEFEND);
        add_row(5'b10000, 1'b0, fighter_pkg::ACT_RIGHT);
        add_row(5'b01000, 1'b0, fighter_pkg::ACT_LEFT);
        add_row(5'b00000, 1'b0, fighter_pkg::ACT_IDLE);
        add_row(5'b00010, 1'b0, fighter_pkg::ACT_SQUAT);
        // held off, the fifth action finds the queue full
        add_row(5'b10000, 1'b1, fighter_pkg::ACT_RIGHT);
        add_row(5'b10000, 1'b1, fighter_pkg::ACT_RIGHT);
        add_row(5'b00010, 1'b1, fighter_pkg::ACT_SQUAT);
        add_row(5'b00001, 1'b1, fighter_pkg::ACT_DEFEND);
        add_row(5'b01000, 1'b1, fighter_pkg::ACT_LEFT);
        add_row(5'b00000, 1'b0, fighter_pkg::ACT_IDLE);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n      = 1'b0;
        frame_tick = 1'b0;
        pause      = 1'b0;
        {right, left, jump, squat, defend} = 5'b00000;
        build_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs();
        check_bit("queue_empty", queue_empty, 1'b1);
        foreach (rows[i]) begin
            if (!timed_out) begin
                if (!rows[i].pause && held.size() > 0)
                    release_pause();
                run_frame(rows[i]);
            end
        end
        $display("%0d checks run, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* flist.f */
logic/fighter_pkg.sv
logic/action_if.sv
logic/pad_decoder.sv
logic/action_queue.sv
logic/player_motion.sv
logic/fighter_top.sv
dv/fighter_assert.sv
dv/fighter_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module fighter_tb \
    -o fighter_sim \
    && ./obj_dir/fighter_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
